// ==== hdl/disk_bridge_pkg.sv ====
package disk_bridge_pkg;

	// ========================================================================
	// Sizes
	// ========================================================================

	// One host sector held in the bridge
	localparam int SECTOR_BYTES = 512;
	localparam int BUF_AW       = 9;

	// LBA and image size share one width
	localparam int LBA_W        = 32;

	// Host image slots, selected from drive number bits 2 and 0
	localparam int NUM_SLOTS    = 4;
	localparam int SLOT_W       = $clog2(NUM_SLOTS);

	localparam int DRV_W        = 3;
	localparam int FTYPE_W      = 2;

	// ========================================================================
	// Controller side
	// ========================================================================

	// Register outputs and strobes from the I/O processor
	typedef struct packed {
		logic             lba_sel;
		logic             block_rd;
		logic             block_wr;
		logic [DRV_W-1:0] drv_num;
		logic [LBA_W-1:0] data;
		logic             data_wr;
		logic             data_rd;
		logic             io_wr;
	} ctrl_port_t;

	// Single-cycle commands from the strobe decoder
	typedef struct packed {
		logic              lba_load;
		logic              buf_write;
		logic              buf_advance;
		logic              ptr_clear;
		logic              req_rd;
		logic              req_wr;
		logic [SLOT_W-1:0] slot;
	} ctrl_cmd_t;

	// Status byte, io_done sits in bit 0
	typedef struct packed {
		logic               read_only;
		logic [FTYPE_W-1:0] file_type;
		logic [DRV_W-1:0]   file_no;
		logic               mounted;
		logic               io_done;
	} ctrl_status_t;

	// ========================================================================
	// Host side
	// ========================================================================

	// Host port of the sector buffer
	typedef struct packed {
		logic [BUF_AW-1:0] addr;
		logic [7:0]        wdata;
		logic              we;
	} host_buf_t;

endpackage

// ==== hdl/ctrl_cmd_decoder.sv ====
`timescale 1ns/100ps

module ctrl_cmd_decoder import disk_bridge_pkg::*; (
	input  logic       clk_sys,
	input  logic       areset,
	input  ctrl_port_t ctrl_i,
	output ctrl_cmd_t  cmd_o
);

	// First stage samples the controller levels
	logic             lba_sel_q;
	logic [DRV_W-1:0] drv_q;
	logic             wr_q;
	logic             rd_q;
	logic             io_q;
	logic             blrd_q;
	logic             blwr_q;

	// Second stage holds the previous sample for edge detection
	logic wr_qq;
	logic rd_qq;
	logic blrd_qq;
	logic blwr_qq;

	ctrl_cmd_t cmd_q;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			lba_sel_q <= 1'b0;
			drv_q     <= '0;
			wr_q      <= 1'b0;
			rd_q      <= 1'b0;
			io_q      <= 1'b0;
			blrd_q    <= 1'b0;
			blwr_q    <= 1'b0;
			wr_qq     <= 1'b0;
			rd_qq     <= 1'b0;
			blrd_qq   <= 1'b0;
			blwr_qq   <= 1'b0;
		end else begin
			lba_sel_q <= ctrl_i.lba_sel;
			drv_q     <= ctrl_i.drv_num;
			wr_q      <= ctrl_i.data_wr;
			rd_q      <= ctrl_i.data_rd;
			io_q      <= ctrl_i.io_wr;
			blrd_q    <= ctrl_i.block_rd;
			blwr_q    <= ctrl_i.block_wr;
			wr_qq     <= wr_q;
			rd_qq     <= rd_q;
			blrd_qq   <= blrd_q;
			blwr_qq   <= blwr_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			cmd_q <= '0;
		end else begin
			// Write edge goes to the LBA register or into the buffer
			cmd_q.lba_load    <= wr_q & ~wr_qq & lba_sel_q;
			cmd_q.buf_write   <= wr_q & ~wr_qq & ~lba_sel_q;
			// Read completes on the falling edge
			cmd_q.buf_advance <= rd_qq & ~rd_q;
			cmd_q.ptr_clear   <= io_q;
			cmd_q.req_rd      <= blrd_q & ~blrd_qq;
			cmd_q.req_wr      <= blwr_q & ~blwr_qq;
			cmd_q.slot        <= {drv_q[2], drv_q[0]};
		end
	end

	assign cmd_o = cmd_q;

	a_req_excl: assert property (@(posedge clk_sys) disable iff (areset)
		!(cmd_o.req_rd && cmd_o.req_wr));

endmodule

// ==== hdl/sector_buffer.sv ====
`timescale 1ns/100ps

module sector_buffer import disk_bridge_pkg::*; (
	input  logic             clk_sys,
	input  logic             areset,
	input  ctrl_cmd_t        cmd_i,
	input  logic [LBA_W-1:0] wdata_i,
	input  host_buf_t        host_buf_i,
	output logic [7:0]       host_rdata_o,
	output logic [7:0]       ctrl_rdata_o,
	output logic [LBA_W-1:0] host_lba_o
);

	logic [7:0]        mem [SECTOR_BYTES];
	logic [BUF_AW-1:0] ptr;
	logic [LBA_W-1:0]  lba;
	logic [7:0]        ctrl_rdata;
	logic [7:0]        host_rdata;

	// ========================================================================
	// Controller pointer and LBA
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ptr <= '0;
		end else if (cmd_i.ptr_clear) begin
			// Clear wins over a pending advance
			ptr <= '0;
		end else if (cmd_i.buf_write || cmd_i.buf_advance) begin
			ptr <= ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cmd_i.lba_load) begin
			lba <= wdata_i;
		end
	end

	// ========================================================================
	// Dual-port RAM
	// ========================================================================

	// Controller port, low byte of the data word
	always @(posedge clk_sys) begin
		if (cmd_i.buf_write) begin
			mem[ptr] <= wdata_i[7:0];
		end
		ctrl_rdata <= mem[ptr];
	end

	// Host port
	always @(posedge clk_sys) begin
		if (host_buf_i.we) begin
			mem[host_buf_i.addr] <= host_buf_i.wdata;
		end
		host_rdata <= mem[host_buf_i.addr];
	end

	assign ctrl_rdata_o = ctrl_rdata;
	assign host_rdata_o = host_rdata;
	assign host_lba_o   = lba;

	a_wr_clr_excl: assert property (@(posedge clk_sys) disable iff (areset)
		!(cmd_i.buf_write && cmd_i.ptr_clear));

endmodule

// ==== hdl/host_request_tracker.sv ====
`timescale 1ns/100ps

module host_request_tracker import disk_bridge_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 areset,
	input  ctrl_cmd_t            cmd_i,
	input  logic [NUM_SLOTS-1:0] host_ack_i,
	input  logic [NUM_SLOTS-1:0] img_mounted_i,
	input  logic                 img_readonly_i,
	input  logic [LBA_W-1:0]     img_size_i,
	input  logic [FTYPE_W-1:0]   file_type_i,
	output logic [NUM_SLOTS-1:0] host_rd_o,
	output logic [NUM_SLOTS-1:0] host_wr_o,
	output ctrl_status_t         status_o,
	output logic [LBA_W-1:0]     file_size_o
);

	logic [NUM_SLOTS-1:0] rd_req;
	logic [NUM_SLOTS-1:0] wr_req;
	logic                 ack_q;
	logic                 mnt_q;
	logic [SLOT_W-1:0]    mnt_slot;
	ctrl_status_t         status_q;
	logic [LBA_W-1:0]     file_size;

	// Highest mounted slot wins
	always_comb begin
		mnt_slot = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (img_mounted_i[i]) begin
				mnt_slot = SLOT_W'(i);
			end
		end
	end

	// ========================================================================
	// Block requests and completion
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			rd_req           <= '0;
			wr_req           <= '0;
			ack_q            <= 1'b0;
			status_q.io_done <= 1'b0;
		end else begin
			if (cmd_i.req_rd) begin
				rd_req[cmd_i.slot] <= 1'b1;
				status_q.io_done   <= 1'b0;
			end
			if (cmd_i.req_wr) begin
				wr_req[cmd_i.slot] <= 1'b1;
				status_q.io_done   <= 1'b0;
			end
			// Host took the request
			if (|host_ack_i) begin
				rd_req <= '0;
				wr_req <= '0;
			end
			ack_q <= |host_ack_i;
			if (ack_q && !(|host_ack_i)) begin
				status_q.io_done <= 1'b1;
			end
		end
	end

	// ========================================================================
	// Image mount status
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mnt_q              <= 1'b0;
			status_q.mounted   <= 1'b0;
			status_q.file_no   <= '0;
			status_q.file_type <= '0;
			status_q.read_only <= 1'b0;
			file_size          <= '0;
		end else begin
			mnt_q <= |img_mounted_i;
			if (!mnt_q && |img_mounted_i) begin
				// Slots 0..3 appear as files 0, 1, 4, 5
				status_q.file_no   <= {mnt_slot[1], 1'b0, mnt_slot[0]};
				status_q.file_type <= file_type_i;
				status_q.read_only <= img_readonly_i | (|img_mounted_i[3:2]);
				status_q.mounted   <= ~status_q.mounted;
				file_size          <= img_size_i;
			end
		end
	end

	assign host_rd_o   = rd_req;
	assign host_wr_o   = wr_req;
	assign status_o    = status_q;
	assign file_size_o = file_size;

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (areset)
		!(|host_rd_o && |host_wr_o));

endmodule

// ==== hdl/disk_bridge_top.sv ====
`timescale 1ns/100ps

module disk_bridge_top import disk_bridge_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 areset,
	input  ctrl_port_t           ctrl_i,
	input  host_buf_t            host_buf_i,
	input  logic [NUM_SLOTS-1:0] host_ack_i,
	input  logic [NUM_SLOTS-1:0] img_mounted_i,
	input  logic                 img_readonly_i,
	input  logic [LBA_W-1:0]     img_size_i,
	input  logic [FTYPE_W-1:0]   file_type_i,
	output logic [NUM_SLOTS-1:0] host_rd_o,
	output logic [NUM_SLOTS-1:0] host_wr_o,
	output logic [LBA_W-1:0]     host_lba_o,
	output logic [7:0]           host_rdata_o,
	output ctrl_status_t         status_o,
	output logic [LBA_W-1:0]     data_o
);

	ctrl_cmd_t        cmd;
	logic [7:0]       ctrl_rdata;
	logic [LBA_W-1:0] file_size;

	ctrl_cmd_decoder i_ctrl_cmd_decoder (
		.clk_sys (clk_sys),
		.areset  (areset),
		.ctrl_i  (ctrl_i),
		.cmd_o   (cmd)
	);

	sector_buffer i_sector_buffer (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.cmd_i        (cmd),
		.wdata_i      (ctrl_i.data),
		.host_buf_i   (host_buf_i),
		.host_rdata_o (host_rdata_o),
		.ctrl_rdata_o (ctrl_rdata),
		.host_lba_o   (host_lba_o)
	);

	host_request_tracker i_host_request_tracker (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.cmd_i          (cmd),
		.host_ack_i     (host_ack_i),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.file_type_i    (file_type_i),
		.host_rd_o      (host_rd_o),
		.host_wr_o      (host_wr_o),
		.status_o       (status_o),
		.file_size_o    (file_size)
	);

	// Readback word, image size or the byte under the pointer
	assign data_o = ctrl_i.lba_sel ? file_size : {{(LBA_W-8){1'b0}}, ctrl_rdata};

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
	output logic clk_o,
	output logic areset_o
);

	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// Power-on reset for two cycles, released just after an edge
	initial begin
		areset_o = 1'b1;
		repeat (2) @(posedge clk_o);
		#1 areset_o = 1'b0;
	end

endmodule

// ==== bench/disk_bridge_tb.sv ====
`timescale 1ns/100ps

module disk_bridge_tb import disk_bridge_pkg::*; ();

	// Strobe hold and gap in cycles exceed the 4-cycle minimum spacing
	localparam int GAP     = 6;
	localparam int TIMEOUT = 50;

	logic                 clk_sys;
	logic                 por;
	logic                 extra_reset;
	logic                 areset;
	ctrl_port_t           ctrl;
	host_buf_t            host_buf;
	logic [NUM_SLOTS-1:0] host_ack;
	logic [NUM_SLOTS-1:0] img_mounted;
	logic                 img_readonly;
	logic [LBA_W-1:0]     img_size;
	logic [FTYPE_W-1:0]   file_type;
	logic [NUM_SLOTS-1:0] host_rd;
	logic [NUM_SLOTS-1:0] host_wr;
	logic [LBA_W-1:0]     host_lba;
	logic [7:0]           host_rdata;
	ctrl_status_t         status;
	logic [LBA_W-1:0]     data;

	// Reference model state
	logic [7:0]           m_mem [SECTOR_BYTES];
	logic [BUF_AW-1:0]    m_ptr;
	logic [LBA_W-1:0]     m_lba;
	logic [NUM_SLOTS-1:0] m_rd;
	logic [NUM_SLOTS-1:0] m_wr;
	logic                 m_io_done;
	logic                 m_mounted;
	logic [DRV_W-1:0]     m_file_no;
	logic [FTYPE_W-1:0]   m_ftype;
	logic                 m_ro;
	logic [LBA_W-1:0]     m_size;

	integer seed = 32'h722dc054;
	int     checks;
	int     errors;
	int     test_errors;

	clk_gen i_clk_gen (
		.clk_o    (clk_sys),
		.areset_o (por)
	);

	assign areset = por | extra_reset;

	disk_bridge_top i_disk_bridge_top (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.ctrl_i         (ctrl),
		.host_buf_i     (host_buf),
		.host_ack_i     (host_ack),
		.img_mounted_i  (img_mounted),
		.img_readonly_i (img_readonly),
		.img_size_i     (img_size),
		.file_type_i    (file_type),
		.host_rd_o      (host_rd),
		.host_wr_o      (host_wr),
		.host_lba_o     (host_lba),
		.host_rdata_o   (host_rdata),
		.status_o       (status),
		.data_o         (data)
	);

	// ========================================================================
	// Helpers
	// ========================================================================

	// Inputs change 1 ns after the rising edge
	task automatic cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error: %s is %h, expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$finish;
	endtask

	task automatic end_test(input string name);
		$display("%s finished with %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (areset !== 1'b0 && n < TIMEOUT);
		if (areset !== 1'b0)
			abort_run("timeout: reset was never released");
		#1;
	endtask

	task automatic wait_request();
		int n;
		n = 0;
		while ((host_rd | host_wr) == '0 && n < TIMEOUT) begin
			cycles(1);
			n++;
		end
		if ((host_rd | host_wr) == '0)
			abort_run("timeout: no block request reached the host");
	endtask

	task automatic wait_io_done();
		int n;
		n = 0;
		while (status.io_done !== 1'b1 && n < TIMEOUT) begin
			cycles(1);
			n++;
		end
		if (status.io_done !== 1'b1)
			abort_run("timeout: io_done never set after the host acknowledge");
	endtask

	task automatic pulse_data_wr(input logic [LBA_W-1:0] word);
		ctrl.data    = word;
		ctrl.data_wr = 1'b1;
		cycles(GAP);
		ctrl.data_wr = 1'b0;
		cycles(GAP);
	endtask

	task automatic pulse_data_rd();
		ctrl.data_rd = 1'b1;
		cycles(GAP);
		ctrl.data_rd = 1'b0;
		cycles(GAP);
	endtask

	task automatic pulse_io_wr();
		ctrl.io_wr = 1'b1;
		cycles(GAP);
		ctrl.io_wr = 1'b0;
		cycles(GAP);
	endtask

	task automatic model_reset();
		m_ptr     = '0;
		m_rd      = '0;
		m_wr      = '0;
		m_io_done = 1'b0;
		m_mounted = 1'b0;
		m_file_no = '0;
		m_ftype   = '0;
		m_ro      = 1'b0;
		m_size    = '0;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic run_lba_load();
		logic [LBA_W-1:0] word;
		ctrl.lba_sel = 1'b1;
		for (int i = 0; i < 4; i++) begin
			word = $random(seed);
			pulse_data_wr(word);
			m_lba = word;
			compare("host_lba_o", host_lba, m_lba);
		end
		ctrl.lba_sel = 1'b0;
		end_test("lba load");
	endtask

	task automatic run_ctrl_fill();
		logic [LBA_W-1:0] word;
		pulse_io_wr();
		m_ptr = '0;
		for (int i = 0; i < 16; i++) begin
			word = $random(seed);
			pulse_data_wr(word);
			m_mem[m_ptr] = word[7:0];
			m_ptr++;
		end
		// One-cycle read latency on the host port
		for (int i = 0; i < 16; i++) begin
			host_buf.addr = BUF_AW'(i);
			cycles(1);
			compare("host_rdata_o", host_rdata, m_mem[i]);
		end
		end_test("controller fill");
	endtask

	task automatic run_host_fill();
		for (int i = 0; i < 16; i++) begin
			host_buf.addr  = BUF_AW'(i);
			host_buf.wdata = 8'($random(seed));
			host_buf.we    = 1'b1;
			m_mem[i]       = host_buf.wdata;
			cycles(1);
		end
		host_buf.we = 1'b0;
		pulse_io_wr();
		m_ptr = '0;
		for (int i = 0; i < 16; i++) begin
			compare("data_o", data, {24'h0, m_mem[m_ptr]});
			pulse_data_rd();
			m_ptr++;
		end
		end_test("host fill");
	endtask

	task automatic run_block_requests();
		logic [DRV_W-1:0]  drv;
		logic              dir_wr;
		logic [SLOT_W-1:0] slot;
		for (int i = 0; i < 8; i++) begin
			drv          = DRV_W'($random(seed));
			dir_wr       = 1'($random(seed));
			slot         = {drv[2], drv[0]};
			ctrl.drv_num = drv;
			if (dir_wr) begin
				ctrl.block_wr = 1'b1;
				m_wr[slot]    = 1'b1;
			end else begin
				ctrl.block_rd = 1'b1;
				m_rd[slot]    = 1'b1;
			end
			m_io_done = 1'b0;
			wait_request();
			compare("host_rd_o", host_rd, m_rd);
			compare("host_wr_o", host_wr, m_wr);
			compare("status_o.io_done", status.io_done, m_io_done);
			ctrl.block_rd = 1'b0;
			ctrl.block_wr = 1'b0;
			cycles(GAP);
			// Host holds ack while it services the sector
			host_ack       = '0;
			host_ack[slot] = 1'b1;
			cycles(3);
			// Requests are gone but completion waits for the ack to drop
			m_rd = '0;
			m_wr = '0;
			compare("host_rd_o", host_rd, m_rd);
			compare("host_wr_o", host_wr, m_wr);
			compare("status_o.io_done", status.io_done, m_io_done);
			host_ack = '0;
			wait_io_done();
		end
		end_test("block requests");
	endtask

	task automatic run_mount_status();
		logic [SLOT_W-1:0] slot;
		for (int i = 0; i < 3; i++) begin
			slot         = SLOT_W'($random(seed));
			img_size     = $random(seed);
			file_type    = FTYPE_W'($random(seed));
			img_readonly = 1'($random(seed));
			img_mounted  = '0;
			img_mounted[slot] = 1'b1;
			case (slot)
				2'd0:    m_file_no = 3'd0;
				2'd1:    m_file_no = 3'd1;
				2'd2:    m_file_no = 3'd4;
				default: m_file_no = 3'd5;
			endcase
			m_ftype   = file_type;
			m_ro      = img_readonly || slot >= 2;
			m_mounted = ~m_mounted;
			m_size    = img_size;
			cycles(1);
			img_mounted = '0;
			cycles(GAP);
			compare("status_o.file_no", status.file_no, m_file_no);
			compare("status_o.file_type", status.file_type, m_ftype);
			compare("status_o.read_only", status.read_only, m_ro);
			compare("status_o.mounted", status.mounted, m_mounted);
			ctrl.lba_sel = 1'b1;
			cycles(1);
			compare("data_o", data, m_size);
			ctrl.lba_sel = 1'b0;
		end
		// A later reset drops the mount state
		extra_reset = 1'b1;
		cycles(2);
		extra_reset = 1'b0;
		cycles(2);
		model_reset();
		compare("status_o.mounted", status.mounted, m_mounted);
		compare("status_o.file_no", status.file_no, m_file_no);
		compare("status_o.file_type", status.file_type, m_ftype);
		compare("status_o.read_only", status.read_only, m_ro);
		compare("status_o.io_done", status.io_done, m_io_done);
		// Pointer is back on the first byte
		compare("data_o", data, {24'h0, m_mem[m_ptr]});
		ctrl.lba_sel = 1'b1;
		cycles(1);
		compare("data_o", data, m_size);
		ctrl.lba_sel = 1'b0;
		end_test("mount status");
	endtask

	initial begin
		extra_reset  = 1'b0;
		ctrl         = '0;
		host_buf     = '0;
		host_ack     = '0;
		img_mounted  = '0;
		img_readonly = 1'b0;
		img_size     = '0;
		file_type    = '0;
		checks       = 0;
		errors       = 0;
		test_errors  = 0;
		m_lba        = '0;
		model_reset();
		wait_reset_release();
		run_lba_load();
		run_ctrl_fill();
		run_host_fill();
		run_block_requests();
		run_mount_status();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/disk_bridge_pkg.sv
hdl/ctrl_cmd_decoder.sv
hdl/sector_buffer.sv
hdl/host_request_tracker.sv
hdl/disk_bridge_top.sv
bench/clk_gen.sv
bench/disk_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: disk_bridge

sources:
  - files:
      - hdl/disk_bridge_pkg.sv
      - hdl/ctrl_cmd_decoder.sv
      - hdl/sector_buffer.sv
      - hdl/host_request_tracker.sv
      - hdl/disk_bridge_top.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/disk_bridge_tb.sv
